// ==== design/hacd_consts.svh ====
// widths, translation table size, free-page list placement
// and stall buffer depth for the hacd core
`ifndef HACD_CONSTS_SVH
`define HACD_CONSTS_SVH

//////////////////////////////////////////////////
// datapath widths
`define HACD_DATA_W       32
`define HACD_PAGE_W       4   // page number, 16 ATT entries
`define HACD_OFFSET_W     12  // byte offset inside a page
`define HACD_MC_ADDR_W    16  // page + offset toward memory
`define HACD_CPU_ADDR_W   17  // msb selects the ATT window

// translation table
`define HACD_ATT_ENTRIES  (1 << `HACD_PAGE_W)

//////////////////////////////////////////////////
// free-page list written at init
`define HACD_LIST_BASE        16'hF000
`define HACD_LIST_ENTRIES     8
`define HACD_FREE_PAGE_FIRST  8   // word i holds first + i

// cpu requests held while init runs
`define HACD_STALL_DEPTH  4

`endif

// ==== design/hacd_bus_pkg.sv ====
// request and response structs for the cpu and memory ports,
// plus the two decodes of a cpu address
package hacd_bus_pkg;

`include "hacd_consts.svh"

   // normal memory view of a cpu address
   typedef struct packed {
      logic                      win;     // 0 here
      logic [`HACD_PAGE_W-1:0]   page;
      logic [`HACD_OFFSET_W-1:0] offset;
   } mem_addr_t;

   // ATT window view, index picks a table entry
   typedef struct packed {
      logic                                      win;   // 1 here
      logic [`HACD_CPU_ADDR_W-1-`HACD_PAGE_W-1:0] pad;   // ignored
      logic [`HACD_PAGE_W-1:0]                   idx;
   } att_addr_t;

   // same 17 bit word, decoded by the window flag
   typedef union packed {
      mem_addr_t mem;
      att_addr_t att;
   } cpu_addr_u;

   typedef struct packed {
      logic                    valid;
      logic                    write;
      cpu_addr_u               addr;
      logic [`HACD_DATA_W-1:0] data;
   } cpu_req_t;   // 51 bits

   typedef struct packed {
      logic                       valid;
      logic                       write;
      logic [`HACD_MC_ADDR_W-1:0] addr;
      logic [`HACD_DATA_W-1:0]    data;
   } mc_req_t;    // 50 bits

   // read data back, memory side and cpu side alike
   typedef struct packed {
      logic                    valid;
      logic [`HACD_DATA_W-1:0] data;
   } rsp_t;

endpackage

// ==== design/hacd_ctrl_pkg.sv ====
// control phase encoding, broadcast state, init handshakes
// and ATT update record
package hacd_ctrl_pkg;

`include "hacd_consts.svh"

   typedef enum logic [1:0] {
      IDLE      = 2'd0,
      INIT_ATT  = 2'd1,   // identity fill of the table
      INIT_LIST = 2'd2,   // free-page list toward memory
      ACTIVE    = 2'd3
   } hacd_phase_e;

   // broadcast from the control unit
   typedef struct packed {
      hacd_phase_e phase;
      logic        bypass;   // inactive core, no translation
   } ctrl_state_t;

   typedef struct packed {
      logic att_start;
      logic att_done;
      logic list_start;
      logic list_done;
   } init_hs_t;

   // one table write, from init or from the window
   typedef struct packed {
      logic                    valid;
      logic [`HACD_PAGE_W-1:0] index;
      logic [`HACD_PAGE_W-1:0] page;
   } att_upd_t;

endpackage

// ==== design/hacd_ctrl_unit.sv ====
// control unit: phase FSM sequencing ATT fill, then list write,
// or jumping straight to active in bypass
`timescale 1ns/1ns

module hacd_ctrl_unit
   import hacd_ctrl_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        hawk_inactive_i,
   input  logic        att_done_i,    // from hacd_att
   input  logic        list_done_i,   // from page writer
   output logic        att_start_o,
   output logic        list_start_o,
   output ctrl_state_t state_o
);

   hacd_phase_e phase_q;
   logic        bypass_q;

   //////////////////////////////////////////////////
   // phase sequencer
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         phase_q      <= IDLE;
         bypass_q     <= 1'b0;
         att_start_o  <= 1'b0;
         list_start_o <= 1'b0;
      end else begin
         att_start_o  <= 1'b0;   // strobes, one cycle only
         list_start_o <= 1'b0;
         case (phase_q)
            IDLE: begin
               bypass_q <= hawk_inactive_i;   // sampled once after reset
               if (hawk_inactive_i) begin
                  phase_q <= ACTIVE;   // no init at all
               end else begin
                  att_start_o <= 1'b1;
                  phase_q     <= INIT_ATT;
               end
            end
            INIT_ATT: begin
               if (att_done_i) begin
                  list_start_o <= 1'b1;
                  phase_q      <= INIT_LIST;
               end
            end
            INIT_LIST: begin
               if (list_done_i) phase_q <= ACTIVE;
            end
            default: phase_q <= ACTIVE;   // stays until reset
         endcase
      end
   end

   assign state_o = '{phase: phase_q, bypass: bypass_q};

endmodule

// ==== design/hacd_cpu_stall.sv ====
// stall FIFO for cpu requests, drained one per cycle
// once the core is active
`timescale 1ns/1ns
`include "hacd_consts.svh"

module hacd_cpu_stall
   import hacd_bus_pkg::*, hacd_ctrl_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  cpu_req_t    cpu_req_i,
   input  ctrl_state_t state_i,
   output cpu_req_t    req_o     // registered, toward ATT
);

   localparam int PTR_W = $clog2(`HACD_STALL_DEPTH);
   localparam int CNT_W = $clog2(`HACD_STALL_DEPTH + 1);

   cpu_req_t         fifo_mem [`HACD_STALL_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   logic     active;
   logic     push;
   logic     pop;
   cpu_req_t req_nxt;

   assign active = (state_i.phase == ACTIVE);
   assign pop    = active && (count != '0);   // drain oldest first
   // empty and active: request skips the storage
   assign push   = cpu_req_i.valid && !(active && (count == '0));

   always_comb begin
      req_nxt       = cpu_req_i;
      req_nxt.valid = 1'b0;
      if (pop) begin
         req_nxt       = fifo_mem[rd_ptr];
         req_nxt.valid = 1'b1;
      end else if (active && cpu_req_i.valid) begin
         req_nxt = cpu_req_i;   // 1 cycle through path
      end
   end

   //////////////////////////////////////////////////
   // storage, pointers and count
   always_ff @(posedge clk_i) begin
      if (push) fifo_mem[wr_ptr] <= cpu_req_i;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

   always_ff @(posedge clk_i) begin
      req_o <= req_nxt;
      if (!rst_n_i) req_o.valid <= 1'b0;
   end

endmodule

// ==== design/hacd_att.sv ====
// address translation table: identity fill at init, window
// updates from the cpu, registered page lookup
`timescale 1ns/1ns
`include "hacd_consts.svh"

module hacd_att
   import hacd_bus_pkg::*, hacd_ctrl_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  ctrl_state_t state_i,
   input  logic        init_start_i,
   output logic        init_done_o,
   input  cpu_req_t    req_i,
   output mc_req_t     req_o
);

   logic [`HACD_PAGE_W-1:0] att_tbl [`HACD_ATT_ENTRIES];   // page map

   logic                    init_busy;
   logic [`HACD_PAGE_W-1:0] init_cnt;
   logic                    accept;
   logic                    win_hit;
   att_upd_t                upd;
   mc_req_t                 fwd;

   assign accept  = req_i.valid && (state_i.phase == ACTIVE);
   assign win_hit = req_i.addr.mem.win && !state_i.bypass;   // window off in bypass

   //////////////////////////////////////////////////
   // identity fill, one entry per cycle
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         init_busy   <= 1'b0;
         init_cnt    <= '0;
         init_done_o <= 1'b0;
      end else begin
         init_done_o <= 1'b0;
         if (init_start_i) begin
            init_busy <= 1'b1;
            init_cnt  <= '0;
         end else if (init_busy) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == `HACD_PAGE_W'(`HACD_ATT_ENTRIES - 1)) begin
               init_busy   <= 1'b0;
               init_done_o <= 1'b1;   // last entry written this edge
            end
         end
      end
   end

   // table write source, init wins
   always_comb begin
      upd = '0;
      if (init_busy) begin
         upd.valid = 1'b1;
         upd.index = init_cnt;
         upd.page  = init_cnt;
      end else if (accept && win_hit && req_i.write) begin
         upd.valid = 1'b1;
         upd.index = req_i.addr.att.idx;
         upd.page  = req_i.data[`HACD_PAGE_W-1:0];   // low page bits only
      end
   end

   always_ff @(posedge clk_i) begin
      if (upd.valid) att_tbl[upd.index] <= upd.page;
   end

   //////////////////////////////////////////////////
   // lookup and forward
   always_comb begin
      fwd.valid = accept && !win_hit;   // window accesses stop here
      fwd.write = req_i.write;
      fwd.data  = req_i.data;
      if (state_i.bypass)
         fwd.addr = {req_i.addr.mem.page, req_i.addr.mem.offset};
      else
         fwd.addr = {att_tbl[req_i.addr.mem.page], req_i.addr.mem.offset};
   end

   always_ff @(posedge clk_i) begin
      req_o <= fwd;
      if (!rst_n_i) req_o.valid <= 1'b0;
   end

endmodule

// ==== design/hacd_pgwr_mngr.sv ====
// page writer: free-page list, one write per cycle to memory
`timescale 1ns/1ns
`include "hacd_consts.svh"

module hacd_pgwr_mngr
   import hacd_bus_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  logic    start_i,
   output logic    done_o,
   output mc_req_t req_o    // toward the mc mux
);

   localparam int CNT_W = $clog2(`HACD_LIST_ENTRIES);

   logic             busy;
   logic [CNT_W-1:0] ent_cnt;   // list word in flight
   mc_req_t          wr_nxt;

   always_comb begin
      wr_nxt.valid = busy;
      wr_nxt.write = 1'b1;
      wr_nxt.addr  = `HACD_LIST_BASE + `HACD_MC_ADDR_W'(ent_cnt);
      wr_nxt.data  = `HACD_DATA_W'(`HACD_FREE_PAGE_FIRST) + `HACD_DATA_W'(ent_cnt);
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         busy    <= 1'b0;
         ent_cnt <= '0;
         done_o  <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (start_i) begin
            busy    <= 1'b1;
            ent_cnt <= '0;
         end else if (busy) begin
            ent_cnt <= ent_cnt + 1'b1;
            if (ent_cnt == CNT_W'(`HACD_LIST_ENTRIES - 1)) begin
               busy   <= 1'b0;
               done_o <= 1'b1;   // with the last write
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      req_o <= wr_nxt;
      if (!rst_n_i) req_o.valid <= 1'b0;
   end

endmodule

// ==== design/hacd_mc_mux.sv ====
// memory port mux, page writer first, and the registered
// read response return to the cpu
`timescale 1ns/1ns

module hacd_mc_mux
   import hacd_bus_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  mc_req_t pgwr_req_i,
   input  mc_req_t cpu_req_i,   // translated, from ATT
   output mc_req_t mc_req_o,
   input  rsp_t    mc_rsp_i,
   output rsp_t    cpu_rsp_o
);

   mc_req_t sel_req;

   // cpu traffic is held until active, so no real contention
   always_comb begin
      if (pgwr_req_i.valid)
         sel_req = pgwr_req_i;
      else
         sel_req = cpu_req_i;
   end

   //////////////////////////////////////////////////
   // request toward the memory controller
   always_ff @(posedge clk_i) begin
      mc_req_o <= sel_req;
      if (!rst_n_i) mc_req_o.valid <= 1'b0;
   end

   // read data back, one cycle
   always_ff @(posedge clk_i) begin
      cpu_rsp_o <= mc_rsp_i;
      if (!rst_n_i) cpu_rsp_o.valid <= 1'b0;
   end

endmodule

// ==== design/hacd_core.sv ====
// hacd core top: control unit, stall FIFO, ATT,
// page writer and memory mux
`timescale 1ns/1ns

module hacd_core
   import hacd_bus_pkg::*, hacd_ctrl_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  logic     hawk_inactive_i,
   // cpu side
   input  cpu_req_t cpu_req_i,
   output rsp_t     cpu_rsp_o,
   // memory controller side
   output mc_req_t  mc_req_o,
   input  rsp_t     mc_rsp_i
);

   ctrl_state_t ctrl_state;   // broadcast phase and bypass
   init_hs_t    init_hs;
   cpu_req_t    stall_req;    // released cpu traffic
   mc_req_t     att_req;      // translated cpu traffic
   mc_req_t     pgwr_req;     // free-page list writes

   hacd_ctrl_unit u_ctrl_unit (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .hawk_inactive_i (hawk_inactive_i),
      .att_done_i      (init_hs.att_done),
      .list_done_i     (init_hs.list_done),
      .att_start_o     (init_hs.att_start),
      .list_start_o    (init_hs.list_start),
      .state_o         (ctrl_state)
   );

   hacd_cpu_stall u_cpu_stall (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .cpu_req_i (cpu_req_i),
      .state_i   (ctrl_state),
      .req_o     (stall_req)
   );

   hacd_att u_att (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .state_i      (ctrl_state),
      .init_start_i (init_hs.att_start),
      .init_done_o  (init_hs.att_done),
      .req_i        (stall_req),
      .req_o        (att_req)
   );

   hacd_pgwr_mngr u_pgwr_mngr (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .start_i (init_hs.list_start),
      .done_o  (init_hs.list_done),
      .req_o   (pgwr_req)
   );

   hacd_mc_mux u_mc_mux (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .pgwr_req_i (pgwr_req),
      .cpu_req_i  (att_req),
      .mc_req_o   (mc_req_o),
      .mc_rsp_i   (mc_rsp_i),
      .cpu_rsp_o  (cpu_rsp_o)
   );

endmodule

// ==== bench/hacd_core_checker.sv ====
// concurrent assertions on the hacd core: memory port in reset,
// init list traffic, response return and stall FIFO level
`timescale 1ns/1ns
`include "hacd_consts.svh"

module hacd_core_checker
   import hacd_bus_pkg::*, hacd_ctrl_pkg::*;
(
   input logic                                   clk_i,
   input logic                                   rst_n_i,
   input ctrl_state_t                            state_i,      // control unit broadcast
   input mc_req_t                                mc_req_i,
   input rsp_t                                   mc_rsp_i,
   input rsp_t                                   cpu_rsp_i,
   input logic [$clog2(`HACD_STALL_DEPTH+1)-1:0] stall_cnt_i   // FIFO fill level
);

   int assert_fails = 0;   // failed assertions so far

   //////////////////////////////////////////////////
   // memory port quiet one cycle into reset
   no_req_in_reset: assert property (@(posedge clk_i)
      !rst_n_i |=> !mc_req_i.valid)
      else begin
         assert_fails++;
         $error("memory request valid while reset is low");
      end

   // free-page list phase carries writes only
   list_phase_writes: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mc_req_i.valid && (state_i.phase == INIT_LIST) |-> mc_req_i.write)
      else begin
         assert_fails++;
         $error("read request on the memory port during list init");
      end

   // cpu response is the memory response of the cycle before
   rsp_follows_mem: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cpu_rsp_i.valid |-> $past(mc_rsp_i.valid) && (cpu_rsp_i.data == $past(mc_rsp_i.data)))
      else begin
         assert_fails++;
         $error("cpu response without a memory response one cycle earlier");
      end

   stall_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      stall_cnt_i <= `HACD_STALL_DEPTH)
      else begin
         assert_fails++;
         $error("stall FIFO count above its depth");
      end

endmodule

bind hacd_core hacd_core_checker u_checker (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .state_i     (ctrl_state),
   .mc_req_i    (mc_req_o),
   .mc_rsp_i    (mc_rsp_i),
   .cpu_rsp_i   (cpu_rsp_o),
   .stall_cnt_i (u_cpu_stall.count)
);

// ==== bench/hacd_core_tb.sv ====
// hacd core testbench with clock, reset, memory model,
// directed tests, compare tasks and the closing summary
`timescale 1ns/1ns
`include "hacd_consts.svh"

module hacd_core_tb
   import hacd_bus_pkg::*;
();

   localparam int TIMEOUT = 200;   // cycles allowed per wait

   logic     clk_i;
   logic     rst_n_i;
   logic     hawk_inactive_i;
   cpu_req_t cpu_req_i;
   rsp_t     cpu_rsp_o;
   mc_req_t  mc_req_o;
   rsp_t     mc_rsp_i = '0;
   rsp_t     rsp_pipe = '0;   // one-cycle model stage

   integer seed;
   int     value_errs;
   int     other_errs;

   hacd_core dut (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .hawk_inactive_i (hawk_inactive_i),
      .cpu_req_i       (cpu_req_i),
      .cpu_rsp_o       (cpu_rsp_o),
      .mc_req_o        (mc_req_o),
      .mc_rsp_i        (mc_rsp_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // memory model answers a read on mc_req_o 2 cycles later
   always @(negedge clk_i) begin
      mc_rsp_i       <= rsp_pipe;
      rsp_pipe.valid <= mc_req_o.valid && !mc_req_o.write;   // writes get nothing
      rsp_pipe.data  <= mem_read_data(mc_req_o.addr);
   end

   //////////////////////////////////////////////////
   // expected values from the interface rules
   function automatic logic [31:0] mem_read_data(input logic [15:0] addr);
      return {16'h0000, addr} ^ 32'h5a5a0000;
   endfunction

   function automatic mc_req_t list_write(input int i);
      mc_req_t r;
      r.valid = 1'b1;
      r.write = 1'b1;
      r.addr  = `HACD_LIST_BASE + 16'(i);
      r.data  = 32'(`HACD_FREE_PAGE_FIRST + i);   // free page number
      return r;
   endfunction

   function automatic mc_req_t to_mc(input cpu_req_t c, input logic [15:0] addr);
      mc_req_t r;
      r.valid = 1'b1;
      r.write = c.write;
      r.addr  = addr;
      r.data  = c.data;
      return r;
   endfunction

   // plain read with the window flag clear
   function automatic cpu_req_t rand_read();
      cpu_req_t    r;
      logic [31:0] rnd;
      rnd             = $random(seed);
      r.valid         = 1'b1;
      r.write         = 1'b0;
      r.addr.mem.win  = 1'b0;
      r.addr.mem.page = rnd[3:0];
      r.addr.mem.offset = rnd[15:4];
      r.data          = $random(seed);
      return r;
   endfunction

   //////////////////////////////////////////////////
   // drive, wait and compare
   task automatic tick();
      @(posedge clk_i);
      #1;   // outputs settled
   endtask

   task automatic apply_reset(input logic inactive);
      @(negedge clk_i);
      rst_n_i         = 1'b0;
      hawk_inactive_i = inactive;
      cpu_req_i       = '0;
      repeat (8) @(negedge clk_i);
      rst_n_i = 1'b1;
   endtask

   // one cycle strobe on the cpu port
   task automatic send_cpu(input cpu_req_t req);
      @(negedge clk_i);
      cpu_req_i = req;
      @(negedge clk_i);
      cpu_req_i.valid = 1'b0;
   endtask

   task automatic check_mc_req(input string name, input mc_req_t exp, input mc_req_t act);
      if (act !== exp) begin
         value_errs++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_rsp(input string name, input rsp_t exp, input rsp_t act);
      if (act !== exp) begin
         value_errs++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic wait_mc_req(input string name, output mc_req_t req);
      int n;
      n   = 0;
      req = '0;
      do begin
         tick();
         n++;
      end while (!mc_req_o.valid && n < TIMEOUT);
      if (mc_req_o.valid) begin
         req = mc_req_o;
      end else begin
         other_errs++;
         $display("%s: no request reached the memory port in %0d cycles", name, TIMEOUT);
      end
   endtask

   task automatic expect_idle(input string name, input int cycles);
      repeat (cycles) begin
         tick();
         if (mc_req_o.valid) begin
            other_errs++;
            $display("%s: unexpected memory request to %h", name, mc_req_o.addr);
         end
      end
   endtask

   //////////////////////////////////////////////////
   // directed tests
   task automatic list_init_order();
      mc_req_t got;
      apply_reset(1'b0);
      for (int i = 0; i < `HACD_LIST_ENTRIES; i++) begin
         wait_mc_req("list_init", got);
         check_mc_req("list_init", list_write(i), got);
      end
      expect_idle("list_init", 10);   // exactly 8 words
   endtask

   task automatic stall_release_order();
      cpu_req_t reqs [3];
      mc_req_t  got;
      apply_reset(1'b0);
      foreach (reqs[i]) begin   // all land in INIT_ATT
         reqs[i] = rand_read();
         send_cpu(reqs[i]);
      end
      for (int i = 0; i < `HACD_LIST_ENTRIES; i++) begin
         wait_mc_req("stall_release", got);
         check_mc_req("stall_release", list_write(i), got);
      end
      foreach (reqs[i]) begin
         wait_mc_req("stall_release", got);
         check_mc_req("stall_release", to_mc(reqs[i], reqs[i].addr[15:0]), got);
      end
   endtask

   task automatic translate_and_respond();
      cpu_req_t req;
      rsp_t     exp_rsp;
      int       n;
      repeat (6) tick();   // earlier responses drain
      req           = rand_read();
      exp_rsp.valid = 1'b1;
      exp_rsp.data  = mem_read_data(req.addr[15:0]);
      send_cpu(req);
      // stall, ATT and mux registers
      for (int c = 1; c < 3; c++) begin
         if (mc_req_o.valid) begin
            other_errs++;
            $display("translate_rsp: request left the core after %0d cycles, not 3", c);
         end
         tick();
      end
      check_mc_req("translate_rsp", to_mc(req, req.addr[15:0]), mc_req_o);
      n = 0;
      while (!mc_rsp_i.valid && n < TIMEOUT) begin
         tick();
         n++;
      end
      if (!mc_rsp_i.valid) begin
         other_errs++;
         $display("translate_rsp: memory model never answered the read");
      end else begin
         check_rsp("translate_rsp", exp_rsp, cpu_rsp_o);   // registered on that same edge
      end
   endtask

   task automatic table_update();
      cpu_req_t    wr;
      cpu_req_t    rd;
      mc_req_t     got;
      logic [31:0] rnd;
      logic [3:0]  k;
      logic [3:0]  m;
      repeat (6) tick();
      rnd             = $random(seed);
      k               = rnd[3:0];
      m               = k ^ (rnd[7:4] | 4'h1);   // never k itself
      wr.valid        = 1'b1;
      wr.write        = 1'b1;
      wr.addr.att.win = 1'b1;
      wr.addr.att.pad = rnd[19:8];
      wr.addr.att.idx = k;
      wr.data         = {rnd[31:20], 16'h0000, m};   // only low page bits count
      send_cpu(wr);
      expect_idle("table_update", 6);   // window write stays inside
      rd              = rand_read();
      rd.addr.mem.page = k;
      send_cpu(rd);
      wait_mc_req("table_update", got);
      check_mc_req("table_update", to_mc(rd, {m, rd.addr.mem.offset}), got);
   endtask

   task automatic bypass_passthrough();
      cpu_req_t req;
      mc_req_t  got;
      apply_reset(1'b1);
      expect_idle("bypass", 40);   // list writes would be out by now
      for (int w = 0; w < 3; w++) begin
         req = rand_read();
         if (w > 0) begin   // window read and then window write
            req.addr.att.win = 1'b1;
            req.write        = (w == 2);
         end
         send_cpu(req);
         wait_mc_req("bypass", got);
         check_mc_req("bypass", to_mc(req, req.addr[15:0]), got);
      end
   endtask

   //////////////////////////////////////////////////
   initial begin
      seed            = 32'h4f0d;
      value_errs      = 0;
      other_errs      = 0;
      rst_n_i         = 1'b0;
      hawk_inactive_i = 1'b0;
      cpu_req_i       = '0;
      list_init_order();
      stall_release_order();
      translate_and_respond();
      table_update();
      bypass_passthrough();
      repeat (4) tick();
      $display("errors: %0d value, %0d other, %0d assertion",
               value_errs, other_errs, dut.u_checker.assert_fails);
      if (value_errs + other_errs + dut.u_checker.assert_fails == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+design
design/hacd_bus_pkg.sv
design/hacd_ctrl_pkg.sv
design/hacd_ctrl_unit.sv
design/hacd_cpu_stall.sv
design/hacd_att.sv
design/hacd_pgwr_mngr.sv
design/hacd_mc_mux.sv
design/hacd_core.sv
bench/hacd_core_checker.sv
bench/hacd_core_tb.sv
